// File: Makefile
# Verilator build and run of the DDS clock synthesizer testbench

TOP  := dds_synth_tb
SRCS := all.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv bench/*.txt)

.PHONY: all lint clean

# Build, run, then decide on the log contents
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q -F '** PASS **' sim.log

obj_dir/V$(TOP): $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+verilog
verilog/dds_pkg.sv
verilog/dds_regs.sv
verilog/dds_phase_accum.sv
verilog/edge_rate_meter.sv
verilog/dds_synth_top.sv
bench/dds_synth_tb.sv

// File: bench/dds_cases.txt
# case_name increment_hex
# increment is f_out / 600 MHz * 2^32, kept below 2^31
default_12mhz 051eb852
f_1mhz 006d3a06
f_3mhz 0147ae14
f_5mhz 02222222
f_25mhz 0aaaaaab
f_30mhz 0ccccccd
f_50mhz 15555555
f_75mhz 20000000
f_100mhz 2aaaaaab
f_150mhz 40000000
f_200mhz 55555555
f_250mhz 6aaaaaab
near_nyquist 7fffffff
min_incr 00000001
one_edge_per_window 00100000
prime_incr 0000fff1
odd_incr 01234567
pattern_incr 3c3c3c3c

// File: bench/dds_synth_tb.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_synth_tb;

	logic                clk600 = 1'b0;
	logic                rst_n;
	logic                wr_en;
	dds_pkg::reg_addr_t  wr_addr;
	dds_pkg::reg_data_t  wr_data;
	logic                rd_en;
	dds_pkg::reg_addr_t  rd_addr;
	dds_pkg::reg_data_t  rd_data;
	logic                rd_valid;
	logic                dds_out;
	logic                div_out;

	string               case_names[$];  // One entry per line of the cases file
	dds_pkg::incr_t      case_incrs[$];
	int                  seed = 32'h4f99; // Random data for ignored writes
	int                  cycle_cnt = 0;
	int                  cycle_limit = 0; // Zero until the cases are known

	always #50 clk600 = ~clk600; // 100 ns period

	dds_synth_top dut_i (
		.clk600  (clk600),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.rd_valid(rd_valid),
		.dds_out (dds_out),
		.div_out (div_out)
	);

	////////////////////////////////////////////////////////////
	// Failure path and timeout

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on first error");
	endtask

	// Budget of five windows per case plus some slack for reset and the tail
	always @(posedge clk600) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			abort_run($sformatf("Timeout after %0d cycles, the window count stopped advancing",
				cycle_cnt));
		end
	end

	////////////////////////////////////////////////////////////
	// Register strobes

	task automatic write_reg(input dds_pkg::reg_addr_t addr, input dds_pkg::reg_data_t data);
		@(posedge clk600);
		wr_en   <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
		@(posedge clk600);
		wr_en   <= 1'b0; // Single-cycle strobe
	endtask

	// Sampled on the falling edge away from the DUT's updates
	task automatic read_reg(input dds_pkg::reg_addr_t addr, output dds_pkg::reg_data_t data);
		@(posedge clk600);
		rd_en   <= 1'b1;
		rd_addr <= addr;
		@(negedge clk600);
		if (rd_valid !== 1'b0) begin
			abort_run($sformatf("rd_valid came early for the read of address %0d", addr));
		end
		@(posedge clk600);
		rd_en   <= 1'b0;
		@(negedge clk600);
		if (rd_valid !== 1'b1) begin
			abort_run($sformatf("rd_valid did not arrive one cycle after the read of address %0d",
				addr));
		end
		data = rd_data;
	endtask

	////////////////////////////////////////////////////////////
	// Expected values and compares

	// Low bound of edges per window is incr * gate / 2^32
	function automatic dds_pkg::rate_t rate_floor(input dds_pkg::incr_t inc);
		logic [63:0] prod;
		prod = {32'd0, inc} * 64'(`DDS_GATE_CYCLES);
		return dds_pkg::rate_t'(prod >> 32);
	endfunction

	task automatic check_data(input string name, input dds_pkg::reg_data_t exp,
		input dds_pkg::reg_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s: expected %08h actual %08h", name, exp, act));
		end
	endtask

	task automatic check_rate(input string name, input dds_pkg::rate_t lo,
		input dds_pkg::rate_t hi, input dds_pkg::rate_t act);
		if (act < lo || act > hi) begin
			abort_run($sformatf("FAILED %s: expected %0d to %0d actual %0d", name, lo, hi, act));
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s: expected %b actual %b", name, exp, act));
		end
	endtask

	// Polls the window count until it has moved by n
	task automatic wait_windows(input dds_pkg::meas_cnt_t n);
		dds_pkg::reg_data_t d;
		dds_pkg::meas_cnt_t base;
		dds_pkg::meas_cnt_t now;
		read_reg(`DDS_REG_CTRL, d);
		base = dds_pkg::meas_cnt_t'(d);
		now  = base;
		while (dds_pkg::meas_cnt_t'(now - base) < n) begin
			read_reg(`DDS_REG_CTRL, d);
			now = dds_pkg::meas_cnt_t'(d);
		end
	endtask

	// Both rates come from one window read right after it closed
	task automatic check_rates(input string name, input dds_pkg::incr_t inc);
		dds_pkg::reg_data_t d_dds;
		dds_pkg::reg_data_t d_div;
		dds_pkg::rate_t     lo;
		dds_pkg::rate_t     mid;
		read_reg(`DDS_REG_RATE_DDS, d_dds);
		read_reg(`DDS_REG_RATE_DIV, d_div);
		check_data({name, "/rate_dds_upper"}, '0, d_dds >> 16); // Zero-extended
		check_data({name, "/rate_div_upper"}, '0, d_div >> 16);
		lo = rate_floor(inc);
		check_rate({name, "/rate_dds"}, lo, lo + 16'd1, dds_pkg::rate_t'(d_dds));
		mid = dds_pkg::rate_t'(d_dds) / dds_pkg::rate_t'(`DDS_DIV_RATIO);
		check_rate({name, "/rate_div"}, (mid == '0) ? '0 : mid - 16'd1, mid + 16'd1,
			dds_pkg::rate_t'(d_div));
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		int                 fd;
		int                 code;
		string              line;
		string              cname;
		dds_pkg::incr_t     cval;
		dds_pkg::reg_data_t d;
		dds_pkg::reg_data_t rnd;
		dds_pkg::meas_cnt_t c0;
		dds_pkg::incr_t     last_incr;

		rst_n   <= 1'b0;
		wr_en   <= 1'b0;
		wr_addr <= '0;
		wr_data <= '0;
		rd_en   <= 1'b0;
		rd_addr <= '0;

		// Lines starting with '#' in the case table are comments
		fd = $fopen("bench/dds_cases.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open bench/dds_cases.txt");
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "%s %h", cname, cval) == 2) begin
					case_names.push_back(cname);
					case_incrs.push_back(cval);
				end
			end
		end
		$fclose(fd);
		if (case_incrs.size() == 0) begin
			abort_run("The cases file holds no cases");
		end
		cycle_limit = case_incrs.size() * 5 * `DDS_GATE_CYCLES + 1000;

		repeat (3) @(posedge clk600);
		rst_n <= 1'b1; // Release after 3 cycles

		// Both levels start low out of reset
		@(negedge clk600);
		check_level("reset/dds_out", 1'b0, dds_out);
		check_level("reset/div_out", 1'b0, div_out);

		// Reset values
		read_reg(`DDS_REG_INCR, d);
		check_data("reset/incr", `DDS_DEFAULT_INCR, d);
		read_reg(`DDS_REG_RATE_DDS, d);
		check_data("reset/rate_dds", '0, d);
		read_reg(`DDS_REG_RATE_DIV, d);
		check_data("reset/rate_div", '0, d);
		read_reg(`DDS_REG_CTRL, d);
		check_data("reset/window_count", '0, d);

		// Each case programs, reads back and measures, then pokes the read-only registers
		for (int i = 0; i < case_incrs.size(); i++) begin
			write_reg(`DDS_REG_INCR, dds_pkg::reg_data_t'(case_incrs[i]));
			read_reg(`DDS_REG_INCR, d);
			check_data({case_names[i], "/incr"}, dds_pkg::reg_data_t'(case_incrs[i]), d);
			wait_windows(8'd2); // Second window is clean of the old increment
			check_rates(case_names[i], case_incrs[i]);
			rnd = $random(seed);
			write_reg(`DDS_REG_RATE_DDS, rnd);
			rnd = $random(seed);
			write_reg(`DDS_REG_RATE_DIV, rnd);
			wait_windows(8'd1);
			check_rates({case_names[i], "/after_ro_write"}, case_incrs[i]);
		end
		last_incr = case_incrs[case_incrs.size() - 1];

		// Measurement keeps going across a mid-run phase clear
		rnd = $random(seed);
		write_reg(`DDS_REG_CTRL, rnd);
		@(posedge clk600); // Clear pulse lands on this edge
		@(negedge clk600);
		check_level("phase_clear/dds_out", 1'b0, dds_out);
		check_level("phase_clear/div_out", 1'b0, div_out);
		wait_windows(8'd2);
		check_rates("phase_clear", last_incr);

		// Count steps by exactly one per window
		read_reg(`DDS_REG_CTRL, d);
		c0 = dds_pkg::meas_cnt_t'(d);
		while (dds_pkg::meas_cnt_t'(d) == c0) begin
			read_reg(`DDS_REG_CTRL, d);
		end
		check_data("window_step", dds_pkg::reg_data_t'(dds_pkg::meas_cnt_t'(c0 + 8'd1)), d);

		$display("** PASS **");
		$finish;
	end

endmodule

// File: verilog/dds_phase_accum.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_phase_accum (
	input  logic           clk600,
	input  logic           rst_n,
	input  dds_pkg::incr_t incr,        // Programmed increment
	input  logic           phase_clear, // Zero phase and divider
	output logic           dds_out,     // Synthesized clock level
	output logic           div_out      // Divided companion level
);

	// Toggle every half ratio of DDS rising edges
	localparam int DIV_HALF = `DDS_DIV_RATIO / 2;
	localparam int DIV_W    = (DIV_HALF > 1) ? $clog2(DIV_HALF) : 1;

	dds_pkg::incr_t  incr_stage; // Pipelined copy of the increment
	dds_pkg::phase_t phase;
	logic            dds_prev;   // Last cycle's MSB
	logic            dds_rise;
	logic [DIV_W-1:0] div_cnt;   // Rising edges since last toggle

	////////////////////////////////////////////////////////////
	// Phase accumulator

	// Staged every cycle, so a new value lands on the phase one cycle later
	always_ff @(posedge clk600) begin
		incr_stage <= incr;
	end

	always_ff @(posedge clk600) begin
		if (!rst_n || phase_clear) begin
			phase <= '0;
		end else begin
			phase <= phase + incr_stage; // Free-running wrap at 2^32
		end
	end

	// MSB overflows at f = incr / 2^32 * 600 MHz
	assign dds_out = phase[$bits(dds_pkg::phase_t)-1];

	////////////////////////////////////////////////////////////
	// Companion divider

	assign dds_rise = dds_out && !dds_prev; // One pulse per DDS period

	always_ff @(posedge clk600) begin
		if (!rst_n || phase_clear) begin
			dds_prev <= 1'b0;
			div_cnt  <= '0;
			div_out  <= 1'b0;
		end else begin
			dds_prev <= dds_out;
			if (dds_rise) begin
				if (div_cnt == DIV_W'(DIV_HALF - 1)) begin
					div_cnt <= '0;
					div_out <= !div_out; // Half period done
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/dds_pkg.sv
// Shared types for the DDS clock synthesizer

package dds_pkg;

	////////////////////////////////////////////////////////////
	// Datapath widths

	typedef logic [31:0] phase_t;     // Accumulator phase, MSB is the clock
	typedef logic [31:0] incr_t;      // f_out / 600 MHz * 2^32
	typedef logic [15:0] rate_t;      // Rising edges in one gate window
	typedef logic [7:0]  meas_cnt_t;  // Completed windows, wraps

	////////////////////////////////////////////////////////////
	// Register bank

	typedef logic [1:0]  reg_addr_t;  // Four registers
	typedef logic [31:0] reg_data_t;  // One bus word

	////////////////////////////////////////////////////////////
	// Rate meter window controller

	typedef enum logic {
		MEAS_COUNT, // Gate open, edges accumulate
		MEAS_LATCH  // Last gate cycle, result moves to rate
	} meas_state_e;

endpackage

// File: verilog/dds_regs.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_regs (
	input  logic               clk600,
	input  logic               rst_n,

	// Write strobe
	input  logic               wr_en,
	input  dds_pkg::reg_addr_t wr_addr,
	input  dds_pkg::reg_data_t wr_data,

	// Read strobe, answered one cycle later
	input  logic               rd_en,
	input  dds_pkg::reg_addr_t rd_addr,
	output dds_pkg::reg_data_t rd_data,
	output logic               rd_valid,

	// To the accumulator
	output dds_pkg::incr_t     incr,
	output logic               phase_clear,

	// From the rate meters
	input  dds_pkg::rate_t     rate_dds,
	input  logic               rate_dds_done,
	input  dds_pkg::rate_t     rate_div
);

	dds_pkg::meas_cnt_t meas_cnt; // Windows finished by the DDS meter

	////////////////////////////////////////////////////////////
	// Write side

	// Increment register, back to 12 MHz on reset
	always_ff @(posedge clk600) begin
		if (!rst_n) begin
			incr <= `DDS_DEFAULT_INCR;
		end else if (wr_en && (wr_addr == `DDS_REG_INCR)) begin
			incr <= dds_pkg::incr_t'(wr_data);
		end
	end

	// Any write to control gives one clear pulse, data is don't care
	always_ff @(posedge clk600) begin
		if (!rst_n) begin
			phase_clear <= 1'b0;
		end else begin
			phase_clear <= wr_en && (wr_addr == `DDS_REG_CTRL);
		end
	end

	// Writes to the rate registers fall through, nothing to store

	////////////////////////////////////////////////////////////
	// Window counter

	always_ff @(posedge clk600) begin
		if (!rst_n) begin
			meas_cnt <= '0;
		end else if (rate_dds_done) begin
			meas_cnt <= meas_cnt + 1'b1; // Wraps at 256
		end
	end

	////////////////////////////////////////////////////////////
	// Read side

	// Valid follows the strobe by exactly one cycle
	always_ff @(posedge clk600) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
		end
	end

	// Registered read mux, rates sampled in the rd_en cycle
	always_ff @(posedge clk600) begin
		if (rd_en) begin
			case (rd_addr)
				`DDS_REG_INCR:     rd_data <= dds_pkg::reg_data_t'(incr);
				`DDS_REG_RATE_DDS: rd_data <= dds_pkg::reg_data_t'(rate_dds); // Zero-extend
				`DDS_REG_RATE_DIV: rd_data <= dds_pkg::reg_data_t'(rate_div); // Zero-extend
				`DDS_REG_CTRL:     rd_data <= dds_pkg::reg_data_t'(meas_cnt); // Count in [7:0]
				default:           rd_data <= '0;
			endcase
		end
	end

endmodule

// File: verilog/dds_settings.svh
`ifndef DDS_SETTINGS_SVH
`define DDS_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Synthesis defaults

// 12 MHz out of 600 MHz: 0.02 * 2^32
`define DDS_DEFAULT_INCR 32'h051eb852

// Divide ratio of the slow companion level, must be even
`define DDS_DIV_RATIO 8

////////////////////////////////////////////////////////////
// Rate measurement

// Gate window in clk600 cycles, at least 2
`define DDS_GATE_CYCLES 4096

////////////////////////////////////////////////////////////
// Register map

`define DDS_REG_INCR     2'd0  // Increment, read/write
`define DDS_REG_RATE_DDS 2'd1  // Synthesized clock rate, read only
`define DDS_REG_RATE_DIV 2'd2  // Divided clock rate, read only
`define DDS_REG_CTRL     2'd3  // Write clears phase, read gives window count

`endif

// File: verilog/dds_synth_top.sv
`timescale 1ns/1ps

module dds_synth_top (
	input  logic               clk600,
	input  logic               rst_n,

	// Register write strobe
	input  logic               wr_en,
	input  dds_pkg::reg_addr_t wr_addr,
	input  dds_pkg::reg_data_t wr_data,

	// Register read strobe and answer
	input  logic               rd_en,
	input  dds_pkg::reg_addr_t rd_addr,
	output dds_pkg::reg_data_t rd_data,
	output logic               rd_valid,

	// Synthesized levels
	output logic               dds_out,
	output logic               div_out
);

	dds_pkg::incr_t incr;          // Bank to accumulator
	logic           phase_clear;
	dds_pkg::rate_t rate_dds;      // Meter A result
	logic           rate_dds_done; // Meter A window end, drives window count
	dds_pkg::rate_t rate_div;      // Meter B result

	////////////////////////////////////////////////////////////
	// Control registers

	dds_regs regs_i (
		.clk600       (clk600),
		.rst_n        (rst_n),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid),
		.incr         (incr),
		.phase_clear  (phase_clear),
		.rate_dds     (rate_dds),
		.rate_dds_done(rate_dds_done),
		.rate_div     (rate_div)
	);

	////////////////////////////////////////////////////////////
	// Synthesis

	dds_phase_accum accum_i (
		.clk600     (clk600),
		.rst_n      (rst_n),
		.incr       (incr),
		.phase_clear(phase_clear),
		.dds_out    (dds_out),
		.div_out    (div_out)
	);

	////////////////////////////////////////////////////////////
	// Rate monitors, windows aligned from reset

	edge_rate_meter meter_dds (
		.clk600   (clk600),
		.rst_n    (rst_n),
		.sig_in   (dds_out),
		.rate     (rate_dds),
		.rate_done(rate_dds_done)
	);

	// Same window as meter A, so its done pulse is not needed
	edge_rate_meter meter_div (
		.clk600   (clk600),
		.rst_n    (rst_n),
		.sig_in   (div_out),
		.rate     (rate_div),
		.rate_done()
	);

endmodule

// File: verilog/edge_rate_meter.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module edge_rate_meter (
	input  logic           clk600,
	input  logic           rst_n,
	input  logic           sig_in,    // Level to measure, already in clk600
	output dds_pkg::rate_t rate,      // Edges in the last full window
	output logic           rate_done  // Pulse when rate updates
);

	localparam int GATE_W = $clog2(`DDS_GATE_CYCLES);

	dds_pkg::meas_state_e state;
	logic [GATE_W-1:0]    gate_cnt;  // Cycles into the window
	dds_pkg::rate_t       edge_cnt;  // Edges so far this window
	dds_pkg::rate_t       edge_sum;  // Count including this cycle
	logic                 sig_prev;
	logic                 sig_rise;

	assign sig_rise = sig_in && !sig_prev;

	// Saturate, never wrap
	assign edge_sum = (edge_cnt == '1) ? edge_cnt : edge_cnt + sig_rise;

	////////////////////////////////////////////////////////////
	// Window controller

	// COUNT covers GATE-1 cycles, LATCH is the last cycle of the window
	always_ff @(posedge clk600) begin
		if (!rst_n) begin
			state     <= dds_pkg::MEAS_COUNT;
			gate_cnt  <= '0;
			edge_cnt  <= '0;
			sig_prev  <= 1'b0;
			rate      <= '0;
			rate_done <= 1'b0;
		end else begin
			sig_prev  <= sig_in;
			rate_done <= 1'b0;
			case (state)
				dds_pkg::MEAS_COUNT: begin
					edge_cnt <= edge_sum;
					gate_cnt <= gate_cnt + 1'b1;
					if (gate_cnt == GATE_W'(`DDS_GATE_CYCLES - 2)) begin
						state <= dds_pkg::MEAS_LATCH; // Next cycle closes window
					end
				end
				dds_pkg::MEAS_LATCH: begin
					rate      <= edge_sum; // Edge on this cycle still counts
					rate_done <= 1'b1;
					edge_cnt  <= '0;       // Back-to-back, no dead cycle
					gate_cnt  <= '0;
					state     <= dds_pkg::MEAS_COUNT;
				end
				default: state <= dds_pkg::MEAS_COUNT;
			endcase
		end
	end

endmodule
